// ==== logic/microSeqPkg.sv ====
package microSeqPkg;

  // Control store geometry
  localparam int addrWidth  = 11;
  localparam int storeDepth = 2048;
  localparam int wordWidth  = 24;

  // Subroutine return stack
  localparam int stackDepth = 16;
  localparam int ptrWidth   = 4;

  //////////////////////////////////////////////////////////////////////
  // Microword layout
  //////////////////////////////////////////////////////////////////////

  // Bits 23..20 are spare and go straight out with the microword
  localparam int jumpLsb   = 0;
  localparam int jumpMsb   = 10;
  localparam int branchLsb = 11;
  localparam int branchMsb = 18;
  localparam int callBit   = 19;

  // Branch modes, top two bits of the branch field
  localparam logic [1:0] modeJump     = 2'd0;
  localparam logic [1:0] modeDispatch = 2'd1;
  localparam logic [1:0] modeSkip     = 2'd2;
  localparam logic [1:0] modeReturn   = 2'd3;

  // Branch field, read as dispatch or as skip selection
  typedef union packed {
    struct packed {
      logic [1:0] mode;
      logic [2:0] dispSrc;
      logic [2:0] spare;
    } dispView;
    struct packed {
      logic [1:0] mode;
      logic [2:0] condSel;
      logic       invert;
      logic [1:0] spare;
    } skipView;
  } branchField_t;

  // Dispatch sources, anything else ORs in nothing
  localparam logic [2:0] srcInstrTarget = 3'd0;
  localparam logic [2:0] srcDispA       = 3'd1;
  localparam logic [2:0] srcDispB       = 3'd2;

  // Trap entry point
  localparam logic [addrWidth-1:0] trapAddr = '1;

  // Diagnostic register offsets, word granular
  localparam logic [2:0] regAddr     = 3'd0;
  localparam logic [2:0] regCtrl     = 3'd1;
  localparam logic [2:0] regLoadAdr  = 3'd2;
  localparam logic [2:0] regLoadData = 3'd3;
  localparam logic [2:0] regStack    = 3'd4;

endpackage

// ==== logic/sequencerControl.sv ====
`timescale 1ns/1ps

module sequencerControl
  import microSeqPkg::*;
(
  input  logic                 CLK,
  input  logic                 reset,
  input  logic [wordWidth-1:0] microWord,
  input  logic                 trapReq,
  input  logic                 runSet,
  input  logic                 runClear,
  input  logic [addrWidth-1:0] mask,
  input  logic [addrWidth-1:0] stackTop,
  output logic [addrWidth-1:0] microAddr,
  output logic                 running,
  output logic                 push,
  output logic                 pop,
  output logic [addrWidth-1:0] pushValue,
  output branchField_t         branchSel,
  output logic [addrWidth-1:0] nextAddr
);

  logic [addrWidth-1:0] jump;
  logic [addrWidth-1:0] normalNext;
  logic [1:0]           mode;
  logic                 call;

  // Split the current microword into its fields
  assign jump      = microWord[jumpMsb:jumpLsb];
  assign branchSel = microWord[branchMsb:branchLsb];
  assign call      = microWord[callBit];
  // Mode sits in the same place in both views
  assign mode      = branchSel.dispView.mode;

  // Jump field ORed with whatever the datapath selected
  assign normalNext = jump | mask;
  assign nextAddr   = trapReq ? trapAddr : normalNext;

  //////////////////////////////////////////////////////////////////////
  // Stack ordering
  //////////////////////////////////////////////////////////////////////

  // Trap saves the normal next address and takes the only push slot
  // A return under a trap leaves the stack entry in place
  assign push = running && (trapReq || (call && mode != modeReturn));
  assign pop  = running && !trapReq && mode == modeReturn;
  assign pushValue = trapReq ? normalNext : microAddr + 1'b1;

  // Run flag, set wins over clear
  always_ff @(posedge CLK) begin
    if (reset) begin
      running <= 1'b0;
    end else if (runSet) begin
      running <= 1'b1;
    end else if (runClear) begin
      running <= 1'b0;
    end
  end

  // Address register steps only while running
  always_ff @(posedge CLK) begin
    if (reset) begin
      microAddr <= '0;
    end else if (running) begin
      microAddr <= nextAddr;
    end
  end

  // One stack operation per step
  assert property (@(posedge CLK) disable iff (reset) !(push && pop));

  // Address frozen while stopped
  assert property (@(posedge CLK) disable iff (reset)
    !running |=> microAddr == $past(microAddr));

  // A plain return lands on an address covering the popped entry
  assert property (@(posedge CLK) disable iff (reset)
    (running && !trapReq && mode == modeReturn) |-> ((nextAddr & stackTop) == stackTop));

endmodule

// ==== logic/dispatchSelect.sv ====
`timescale 1ns/1ps

module dispatchSelect
  import microSeqPkg::*;
(
  input  branchField_t         branchSel,
  input  logic [addrWidth-1:0] instrTarget,
  input  logic [3:0]           dispA,
  input  logic [3:0]           dispB,
  input  logic [7:0]           cond,
  input  logic [addrWidth-1:0] stackTop,
  output logic [addrWidth-1:0] mask
);

  logic skipBit;

  // Selected condition, optionally inverted
  assign skipBit = cond[branchSel.skipView.condSel] ^ branchSel.skipView.invert;

  //////////////////////////////////////////////////////////////////////
  // OR mask onto the jump field
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    mask = '0;
    case (branchSel.dispView.mode)
      modeDispatch: begin
        // Dispatch view picks the source
        case (branchSel.dispView.dispSrc)
          srcInstrTarget: mask = instrTarget;
          // Multiway sources land in the low nibble
          srcDispA:       mask = {{(addrWidth-4){1'b0}}, dispA};
          srcDispB:       mask = {{(addrWidth-4){1'b0}}, dispB};
          default:        mask = '0;
        endcase
      end
      modeSkip: begin
        // Skip view sets bit 0 only
        mask = {{(addrWidth-1){1'b0}}, skipBit};
      end
      modeReturn: begin
        // Popped return address
        mask = stackTop;
      end
      default: begin
        mask = '0;
      end
    endcase
  end

endmodule

// ==== logic/returnStack.sv ====
`timescale 1ns/1ps

module returnStack
  import microSeqPkg::*;
(
  input  logic                 CLK,
  input  logic                 reset,
  input  logic                 push,
  input  logic                 pop,
  input  logic [addrWidth-1:0] pushValue,
  output logic [addrWidth-1:0] top,
  output logic [ptrWidth-1:0]  ptr
);

  logic [addrWidth-1:0] entries [stackDepth];
  logic [ptrWidth-1:0]  topIdx;

  // Pointer names the next free slot and top reads the one below
  assign topIdx = ptr - 1'b1;
  assign top    = entries[topIdx];

  //////////////////////////////////////////////////////////////////////
  // Pointer wrapping modulo depth
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (reset) begin
      ptr <= '0;
    end else if (push) begin
      ptr <= ptr + 1'b1;
    end else if (pop) begin
      ptr <= ptr - 1'b1;
    end
  end

  // Oldest entry overwritten silently after 16 pushes
  always_ff @(posedge CLK) begin
    if (push) begin
      entries[ptr] <= pushValue;
    end
  end

  // Control side never asks for both in one step
  assert property (@(posedge CLK) disable iff (reset) !(push && pop));

endmodule

// ==== logic/controlStore.sv ====
`timescale 1ns/1ps

module controlStore
  import microSeqPkg::*;
(
  input  logic                 CLK,
  input  logic                 writeEn,
  input  logic [addrWidth-1:0] writeAdr,
  input  logic [wordWidth-1:0] writeData,
  input  logic [addrWidth-1:0] readAdr,
  output logic [wordWidth-1:0] readData
);

  // 2K microwords, contents undefined until loaded
  logic [wordWidth-1:0] mem [storeDepth];

  //////////////////////////////////////////////////////////////////////
  // Load port
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (writeEn) begin
      mem[writeAdr] <= writeData;
    end
  end

  // Read port follows the address within the cycle
  assign readData = mem[readAdr];

endmodule

// ==== logic/diagBusPort.sv ====
`timescale 1ns/1ps

module diagBusPort
  import microSeqPkg::*;
(
  input  logic                 CLK,
  input  logic                 reset,
  input  logic                 cyc,
  input  logic                 stb,
  input  logic                 we,
  input  logic [2:0]           adr,
  input  logic [31:0]          datWrite,
  output logic [31:0]          datRead,
  output logic                 ack,
  input  logic [addrWidth-1:0] microAddr,
  input  logic                 running,
  input  logic [ptrWidth-1:0]  stackPtr,
  input  logic [addrWidth-1:0] stackTop,
  output logic                 runSet,
  output logic                 runClear,
  output logic                 storeWriteEn,
  output logic [addrWidth-1:0] loadAdr,
  output logic [wordWidth-1:0] loadData
);

  logic        access;
  logic        wrAccess;
  logic [31:0] readMux;

  // New cycle seen, ack goes out on the next edge
  assign access   = cyc && stb && !ack;
  assign wrAccess = access && we;

  //////////////////////////////////////////////////////////////////////
  // Write decode, all effects land on the ack edge
  //////////////////////////////////////////////////////////////////////

  assign runSet   = wrAccess && adr == regCtrl && datWrite[0];
  assign runClear = wrAccess && adr == regCtrl && !datWrite[0];
  // Store locked while sequencing, the bus still gets its ack
  assign storeWriteEn = wrAccess && adr == regLoadData && !running;
  assign loadData     = datWrite[wordWidth-1:0];

  always_ff @(posedge CLK) begin
    if (reset) begin
      ack     <= 1'b0;
      loadAdr <= '0;
    end else begin
      ack <= access;
      if (wrAccess && adr == regLoadAdr) begin
        loadAdr <= datWrite[addrWidth-1:0];
      end else if (storeWriteEn) begin
        // Auto increment after each accepted word
        loadAdr <= loadAdr + 1'b1;
      end
    end
  end

  // Readback sources
  always_comb begin
    case (adr)
      regAddr:  readMux = {{(32-addrWidth){1'b0}}, microAddr};
      regCtrl:  readMux = {31'b0, running};
      regStack: readMux = {5'b0, stackTop, 12'b0, stackPtr};
      default:  readMux = '0;
    endcase
  end

  // Captured at the ack edge
  always_ff @(posedge CLK) begin
    if (access && !we) begin
      datRead <= readMux;
    end
  end

  assert property (@(posedge CLK) disable iff (reset) ack |=> !ack);

endmodule

// ==== logic/microSequencer.sv ====
`timescale 1ns/1ps

module microSequencer
  import microSeqPkg::*;
(
  input  logic                 CLK,
  input  logic                 reset,
  // Wishbone diagnostic slave
  input  logic                 cyc,
  input  logic                 stb,
  input  logic                 we,
  input  logic [2:0]           adr,
  input  logic [31:0]          datWrite,
  output logic [31:0]          datRead,
  output logic                 ack,
  // Branch sources
  input  logic [addrWidth-1:0] instrTarget,
  input  logic [3:0]           dispA,
  input  logic [3:0]           dispB,
  input  logic [7:0]           cond,
  input  logic                 trapReq,
  output logic [addrWidth-1:0] microAddr,
  output logic [wordWidth-1:0] microWord
);

  logic                 runSet;
  logic                 runClear;
  logic                 running;
  logic                 push;
  logic                 pop;
  logic [addrWidth-1:0] pushValue;
  branchField_t         branchSel;
  logic [addrWidth-1:0] mask;
  logic [addrWidth-1:0] stackTop;
  logic [ptrWidth-1:0]  stackPtr;
  logic                 storeWriteEn;
  logic [addrWidth-1:0] loadAdr;
  logic [wordWidth-1:0] loadData;

  //////////////////////////////////////////////////////////////////////
  // Sequencing loop
  //////////////////////////////////////////////////////////////////////

  // Next address stays internal to the control block
  sequencerControl control (
    .CLK(CLK), .reset(reset), .microWord(microWord), .trapReq(trapReq),
    .runSet(runSet), .runClear(runClear), .mask(mask), .stackTop(stackTop),
    .microAddr(microAddr), .running(running), .push(push), .pop(pop),
    .pushValue(pushValue), .branchSel(branchSel), .nextAddr()
  );

  dispatchSelect dispatch (
    .branchSel(branchSel), .instrTarget(instrTarget), .dispA(dispA),
    .dispB(dispB), .cond(cond), .stackTop(stackTop), .mask(mask)
  );

  returnStack stack (
    .CLK(CLK), .reset(reset), .push(push), .pop(pop),
    .pushValue(pushValue), .top(stackTop), .ptr(stackPtr)
  );

  // Microword out is the store word at the current address
  controlStore store (
    .CLK(CLK), .writeEn(storeWriteEn), .writeAdr(loadAdr),
    .writeData(loadData), .readAdr(microAddr), .readData(microWord)
  );

  // Diagnostic access
  diagBusPort diag (
    .CLK(CLK), .reset(reset), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
    .datWrite(datWrite), .datRead(datRead), .ack(ack),
    .microAddr(microAddr), .running(running), .stackPtr(stackPtr),
    .stackTop(stackTop), .runSet(runSet), .runClear(runClear),
    .storeWriteEn(storeWriteEn), .loadAdr(loadAdr), .loadData(loadData)
  );

endmodule

// ==== verification/sequencerChecker.sv ====
`timescale 1ns/1ps

module sequencerChecker
  import microSeqPkg::*;
(
  input  logic                 CLK,
  input  logic                 checkEn,
  input  logic [addrWidth-1:0] microAddr,
  input  logic [wordWidth-1:0] microWord,
  input  logic [addrWidth-1:0] expAddr,
  input  logic [wordWidth-1:0] expWord
);

  string curTest;
  int    testErrors;
  int    totalErrors;
  int    passCount;
  int    failCount;

  initial begin
    curTest     = "none";
    testErrors  = 0;
    totalErrors = 0;
    passCount   = 0;
    failCount   = 0;
  end

  task automatic startTest(input string name);
    curTest    = name;
    testErrors = 0;
  endtask

  // Compare one value, print only the first few per test
  task automatic checkValue(input string what, input int expected, input int actual);
    if (expected != actual) begin
      testErrors++;
      totalErrors++;
      if (testErrors <= 5) begin
        $display("MISMATCH %s %s expected 0x%0h actual 0x%0h",
                 curTest, what, expected, actual);
      end
    end
  endtask

  task automatic endTest();
    if (testErrors == 0) begin
      passCount++;
      $display("PASS %s", curTest);
    end else begin
      failCount++;
      $display("FAIL %s with %0d errors", curTest, testErrors);
    end
  endtask

  task automatic summary();
    $display("Tests run %0d, passed %0d, failed %0d, errors %0d",
             passCount + failCount, passCount, failCount, totalErrors);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Sequencing check, sampled mid cycle where everything is settled
  //////////////////////////////////////////////////////////////////////

  always @(negedge CLK) begin
    if (checkEn) begin
      checkValue("microAddr", int'(expAddr), int'(microAddr));
      checkValue("microWord", int'(expWord), int'(microWord));
    end
  end

endmodule

// ==== verification/microSequencerTb.sv ====
`timescale 1ns/1ps

module microSequencerTb;
  import microSeqPkg::*;

  logic                 CLK = 1'b0;
  logic                 reset;
  logic                 cyc;
  logic                 stb;
  logic                 we;
  logic                 trapReq;
  logic                 ack;
  logic [2:0]           adr;
  logic [31:0]          datWrite;
  logic [31:0]          datRead;
  logic [addrWidth-1:0] instrTarget;
  logic [addrWidth-1:0] microAddr;
  logic [3:0]           dispA;
  logic [3:0]           dispB;
  logic [7:0]           cond;
  logic [wordWidth-1:0] microWord;

  // Reference model state
  logic [wordWidth-1:0] modelMem [storeDepth];
  logic [addrWidth-1:0] modelStack [stackDepth];
  logic [ptrWidth-1:0]  modelPtr;
  logic [addrWidth-1:0] modelAddr;
  logic [addrWidth-1:0] predNext;
  logic                 modelRun;
  logic                 pending;
  logic                 checkEn;
  logic                 randIn;
  int                   seedDummy;
  int                   progMode;
  logic [31:0]          rd;

  microSequencer dut (.*);

  sequencerChecker chk (
    .CLK(CLK), .checkEn(checkEn), .microAddr(microAddr), .microWord(microWord),
    .expAddr(modelAddr), .expWord(modelMem[modelAddr])
  );

  always #2 CLK = ~CLK;

  // Random branch sources refreshed every edge
  always @(posedge CLK) begin
    if (randIn) begin
      cond        <= 8'($urandom);
      instrTarget <= addrWidth'($urandom);
      dispA       <= 4'($urandom);
      dispB       <= 4'($urandom);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Next address model evaluated just after each edge
  //////////////////////////////////////////////////////////////////////

  always @(posedge CLK) begin
    logic [wordWidth-1:0] w;
    logic [addrWidth-1:0] m;
    logic [addrWidth-1:0] top;
    logic                 rstSeen;
    // Reset as the DUT sampled it at this edge
    rstSeen = reset;
    #1;
    if (rstSeen) begin
      modelAddr = '0;
      modelPtr  = '0;
      modelRun  = 1'b0;
      pending   = 1'b0;
    end else begin
      if (pending) begin
        modelAddr = predNext;
      end
      pending = 1'b0;
      // Run flag follows a control write at its ack edge
      if (ack && cyc && stb && we && adr == regCtrl) begin
        modelRun = datWrite[0];
      end
      if (modelRun) begin
        w   = modelMem[modelAddr];
        top = modelStack[modelPtr - 1'b1];
        m   = '0;
        case (w[18:17])
          2'd1: m = (w[16:14] == 3'd0) ? instrTarget :
                    (w[16:14] == 3'd1) ? {7'b0, dispA} :
                    (w[16:14] == 3'd2) ? {7'b0, dispB} : '0;
          2'd2: m = {10'b0, cond[w[16:14]] ^ w[13]};
          2'd3: m = top;
          default: m = '0;
        endcase
        if (trapReq) begin
          modelStack[modelPtr] = w[10:0] | m;
          modelPtr = modelPtr + 1'b1;
          predNext = '1;
        end else begin
          predNext = w[10:0] | m;
          if (w[18:17] == 2'd3) begin
            modelPtr = modelPtr - 1'b1;
          end else if (w[19]) begin
            modelStack[modelPtr] = modelAddr + 1'b1;
            modelPtr = modelPtr + 1'b1;
          end
        end
        pending = 1'b1;
      end
    end
  end

  // Ack sampled mid cycle with a bounded wait
  task automatic waitAck();
    int n;
    n = 0;
    do begin
      @(negedge CLK);
      n++;
    end while (!ack && n < 20);
    if (!ack) begin
      $display("Timeout waiting for ack from the diagnostic port");
      $display("TESTS FAILED");
      $finish;
    end
  endtask

  task automatic busWrite(input logic [2:0] a, input logic [31:0] d);
    @(posedge CLK);
    cyc      <= 1'b1;
    stb      <= 1'b1;
    we       <= 1'b1;
    adr      <= a;
    datWrite <= d;
    waitAck();
    @(posedge CLK);
    cyc <= 1'b0;
    stb <= 1'b0;
    we  <= 1'b0;
  endtask

  task automatic busRead(input logic [2:0] a, output logic [31:0] d);
    @(posedge CLK);
    cyc <= 1'b1;
    stb <= 1'b1;
    we  <= 1'b0;
    adr <= a;
    waitAck();
    d = datRead;
    @(posedge CLK);
    cyc <= 1'b0;
    stb <= 1'b0;
  endtask

  // Store one word and keep the model copy in step
  task automatic loadWord(input logic [addrWidth-1:0] a, input logic [wordWidth-1:0] w);
    checkEn = 1'b0;
    busWrite(regLoadAdr, 32'(a));
    modelMem[a] = w;
    busWrite(regLoadData, 32'(w));
    checkEn = 1'b1;
  endtask

  // Whole store of random words restricted by progMode
  task automatic loadRandomStore();
    logic [wordWidth-1:0] w;
    checkEn = 1'b0;
    busWrite(regLoadAdr, 32'd0);
    for (int a = 0; a < storeDepth; a++) begin
      w = wordWidth'($urandom);
      w[19] = 1'b0;
      w[18:17] = (progMode == 2) ? (($urandom % 2) ? 2'd2 : 2'd0) : 2'($urandom % 3);
      modelMem[a] = w;
      busWrite(regLoadData, 32'(w));
    end
    checkEn = 1'b1;
  endtask

  function automatic logic [wordWidth-1:0] mkWord(input logic call, input logic [1:0] mode,
                                                  input logic [addrWidth-1:0] jump);
    return {4'b0, call, mode, 6'b0, jump};
  endfunction

  task automatic runFor(input int cycles);
    busWrite(regCtrl, 32'd1);
    repeat (cycles) @(posedge CLK);
    busWrite(regCtrl, 32'd0);
  endtask

  task automatic resetDut();
    @(posedge CLK);
    reset <= 1'b1;
    repeat (8) @(posedge CLK);
    reset <= 1'b0;
    @(posedge CLK);
  endtask

  initial begin
    seedDummy   = $urandom(6);
    reset       = 1'b1;
    cyc         = 1'b0;
    stb         = 1'b0;
    we          = 1'b0;
    adr         = '0;
    datWrite    = '0;
    instrTarget = '0;
    dispA       = '0;
    dispB       = '0;
    cond        = '0;
    trapReq     = 1'b0;
    checkEn     = 1'b0;
    randIn      = 1'b0;
    resetDut();

    chk.startTest("resetReadback");
    busRead(regAddr, rd);
    chk.checkValue("regAddr", 0, int'(rd));
    busRead(regStack, rd);
    chk.checkValue("stackPtr", 0, int'(rd[3:0]));
    chk.endTest();

    chk.startTest("jumpSkip");
    randIn <= 1'b1;
    progMode = 2;
    loadRandomStore();
    runFor(300);
    chk.endTest();

    chk.startTest("dispatch");
    progMode = 3;
    loadRandomStore();
    runFor(300);
    chk.endTest();

    //////////////////////////////////////////////////////////////////////
    // Nested calls 20 deep so the stack wraps
    //////////////////////////////////////////////////////////////////////
    chk.startTest("callReturn");
    resetDut();
    loadWord(11'h000, mkWord(1'b0, modeJump, 11'h100));
    for (int i = 0; i < 20; i++) begin
      loadWord(11'(11'h100 + 2 * i), mkWord(1'b1, modeJump, 11'(11'h100 + 2 * i + 2)));
      loadWord(11'(11'h101 + 2 * i), mkWord(1'b0, modeReturn, 11'h000));
    end
    loadWord(11'h128, mkWord(1'b0, modeReturn, 11'h000));
    runFor(90);
    busRead(regStack, rd);
    chk.checkValue("stackPtr", int'(modelPtr), int'(rd[3:0]));
    chk.checkValue("stackTop", int'(modelStack[modelPtr - 1'b1]), int'(rd[26:16]));
    chk.endTest();

    chk.startTest("trap");
    resetDut();
    loadWord(11'h000, mkWord(1'b0, modeJump, 11'h200));
    for (int i = 0; i < 16; i++) begin
      loadWord(11'(11'h200 + i), mkWord(1'b0, modeJump, 11'(11'h200 + (i + 1) % 16)));
    end
    loadWord(trapAddr, mkWord(1'b0, modeReturn, 11'h000));
    busWrite(regCtrl, 32'd1);
    repeat (5 + $urandom % 16) @(posedge CLK);
    trapReq <= 1'b1;
    @(posedge CLK);
    trapReq <= 1'b0;
    repeat (30) @(posedge CLK);
    chk.endTest();

    // Store write while running is dropped before the freeze
    chk.startTest("freezeAndLock");
    busWrite(regLoadAdr, 32'h205);
    busWrite(regLoadData, 32'(mkWord(1'b0, modeJump, 11'h300)));
    busWrite(regCtrl, 32'd0);
    repeat (10) @(posedge CLK);
    busRead(regAddr, rd);
    chk.checkValue("frozenAddr", int'(modelAddr), int'(rd));
    runFor(40);
    chk.endTest();

    chk.summary();
    if (chk.totalErrors == 0 && chk.failCount == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
logic/microSeqPkg.sv
logic/sequencerControl.sv
logic/dispatchSelect.sv
logic/returnStack.sv
logic/controlStore.sv
logic/diagBusPort.sv
logic/microSequencer.sv
verification/sequencerChecker.sv
verification/microSequencerTb.sv

// ==== runSim.sh ====
#!/bin/bash
# Build and run the microcode sequencer testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert --timing -f filelist.f \
  --top-module microSequencerTb -o simTb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/simTb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "TESTS FAILED" "$LOG"; then
  exit 1
fi
exit 0
